// ==== tests/rx_payload_q_vectors.hex ====
// test op flow data exp_flag exp_entry; op 0 enqueue, 1 read, 2 probe enq_req_rdy, F end
// exp_flag is is_empty for a read and the expected enq_req_rdy for a probe
01_2_0_00000000_1_00000000
01_2_3_00000000_1_00000000
01_1_0_00000000_1_00000000
01_1_1_00000000_1_00000000
01_1_2_00000000_1_00000000
01_1_3_00000000_1_00000000
02_0_1_11110001_0_00000000
02_0_1_11110002_0_00000000
02_0_1_11110003_0_00000000
02_1_1_00000000_0_11110001
02_1_1_00000000_0_11110002
02_1_1_00000000_0_11110003
03_0_0_A0000001_0_00000000
03_0_1_B0000001_0_00000000
03_0_2_C0000001_0_00000000
03_0_3_D0000001_0_00000000
03_0_0_A0000002_0_00000000
03_1_3_00000000_0_D0000001
03_1_0_00000000_0_A0000001
03_1_1_00000000_0_B0000001
03_1_2_00000000_0_C0000001
03_1_0_00000000_0_A0000002
04_0_2_22220001_0_00000000
04_0_2_22220002_0_00000000
04_0_2_22220003_0_00000000
04_0_2_22220004_0_00000000
04_0_2_22220005_0_00000000
04_0_2_22220006_0_00000000
04_0_2_22220007_0_00000000
04_0_2_22220008_0_00000000
04_2_2_00000000_0_00000000
04_2_1_00000000_1_00000000
04_1_2_00000000_0_22220001
04_0_2_22220009_0_00000000
04_2_2_00000000_0_00000000
05_1_2_00000000_0_22220002
05_1_2_00000000_0_22220003
05_1_2_00000000_0_22220004
05_1_2_00000000_0_22220005
05_1_2_00000000_0_22220006
05_1_2_00000000_0_22220007
05_1_2_00000000_0_22220008
05_1_2_00000000_0_22220009
06_1_2_00000000_1_00000000
06_1_0_00000000_1_00000000
FF_F_0_00000000_0_00000000

// ==== rx_payload_q.f ====
hdl/rx_q_cfg_pkg.sv
hdl/rx_q_types_pkg.sv
hdl/flow_ring_if.sv
hdl/flow_ring.sv
hdl/enqueue_steer.sv
hdl/read_resp_stage.sv
hdl/rx_payload_q.sv
tests/rx_payload_q_chk.sv
tests/rx_payload_q_monitor.sv
tests/rx_payload_q_tb.sv

// ==== Bender.yml ====
package:
  name: rx_payload_q

sources:
  - hdl/rx_q_cfg_pkg.sv
  - hdl/rx_q_types_pkg.sv
  - hdl/flow_ring_if.sv
  - hdl/flow_ring.sv
  - hdl/enqueue_steer.sv
  - hdl/read_resp_stage.sv
  - hdl/rx_payload_q.sv
  - target: test
    files:
      - tests/rx_payload_q_chk.sv
      - tests/rx_payload_q_monitor.sv
      - tests/rx_payload_q_tb.sv

// ==== tests/rx_payload_q_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_payload_q_tb;
    import rx_q_cfg_pkg::*;
    import rx_q_types_pkg::*;

    localparam int VEC_W    = 84;
    localparam int VEC_MAX  = 64;
    localparam int WAIT_MAX = 200;

    logic               clk;
    logic               reset;

    logic               enq_req_val;
    flow_id_t           enq_req_flowid;
    payload_entry_t     enq_req_data;
    logic               enq_req_rdy;

    logic               rd_req_val;
    flow_id_t           rd_req_flowid;
    logic               rd_req_rdy;

    logic               rd_resp_val;
    logic               rd_resp_is_empty;
    payload_entry_t     rd_resp_entry;
    logic               rd_resp_rdy;

    logic [VEC_W-1:0]   vecs [VEC_MAX];
    logic               probe_val;
    int                 probe_idx;
    int                 err_cnt;
    int                 resp_cnt;
    int                 tests_done;
    int                 n_reads;
    logic               run_fail;
    logic [15:0]        lfsr_state;

    rx_payload_q uut (
         .clk               (clk                )
        ,.reset             (reset              )
        ,.enq_req_val       (enq_req_val        )
        ,.enq_req_flowid    (enq_req_flowid     )
        ,.enq_req_data      (enq_req_data       )
        ,.enq_req_rdy       (enq_req_rdy        )
        ,.rd_req_val        (rd_req_val         )
        ,.rd_req_flowid     (rd_req_flowid      )
        ,.rd_req_rdy        (rd_req_rdy         )
        ,.rd_resp_val       (rd_resp_val        )
        ,.rd_resp_is_empty  (rd_resp_is_empty   )
        ,.rd_resp_entry     (rd_resp_entry      )
        ,.rd_resp_rdy       (rd_resp_rdy        )
    );

    rx_payload_q_monitor #(.VEC_W(VEC_W), .VEC_MAX(VEC_MAX)) u_monitor (
         .clk               (clk                )
        ,.reset             (reset              )
        ,.vecs              (vecs               )
        ,.probe_val         (probe_val          )
        ,.probe_idx         (probe_idx          )
        ,.enq_req_rdy       (enq_req_rdy        )
        ,.rd_req_rdy        (rd_req_rdy         )
        ,.rd_resp_val       (rd_resp_val        )
        ,.rd_resp_is_empty  (rd_resp_is_empty   )
        ,.rd_resp_entry     (rd_resp_entry      )
        ,.rd_resp_rdy       (rd_resp_rdy        )
        ,.err_cnt           (err_cnt            )
        ,.resp_cnt          (resp_cnt           )
        ,.tests_done        (tests_done         )
    );

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Response back-pressure takes one LFSR bit per cycle
    initial begin
        rd_resp_rdy = 1'b0;
        lfsr_state  = 16'd91;
        forever begin
            @(posedge clk);
            #1;
            lfsr_state  = lfsr_step(lfsr_state);
            rd_resp_rdy = lfsr_state[0];
        end
    end

    // Tasks start and end 1 ns after a rising edge
    task automatic enqueue_entry(input int idx);
        int waited;
        waited         = 0;
        enq_req_val    = 1'b1;
        enq_req_flowid = vecs[idx][68 +: FLOW_ID_W];
        enq_req_data   = vecs[idx][67:36];
        @(negedge clk);
        while (!enq_req_rdy && waited < WAIT_MAX) begin
            waited++;
            @(negedge clk);
        end
        if (!enq_req_rdy) begin
            $display("timeout: enqueue on line %0d was never accepted", idx);
            run_fail = 1'b1;
        end
        @(posedge clk);
        #1;
        enq_req_val = 1'b0;
    endtask

    task automatic request_read(input int idx);
        int waited;
        waited        = 0;
        rd_req_val    = 1'b1;
        rd_req_flowid = vecs[idx][68 +: FLOW_ID_W];
        @(negedge clk);
        while (!rd_req_rdy && waited < WAIT_MAX) begin
            waited++;
            @(negedge clk);
        end
        if (!rd_req_rdy) begin
            $display("timeout: read on line %0d was never accepted", idx);
            run_fail = 1'b1;
        end
        @(posedge clk);
        #1;
        rd_req_val = 1'b0;
    endtask

    task automatic probe_enq_rdy(input int idx);
        enq_req_flowid = vecs[idx][68 +: FLOW_ID_W];
        probe_idx      = idx;
        probe_val      = 1'b1;
        @(posedge clk);
        #1;
        probe_val = 1'b0;
    endtask

    initial begin
        int vi;
        int waited;
        enq_req_val    = 1'b0;
        enq_req_flowid = '0;
        enq_req_data   = '0;
        rd_req_val     = 1'b0;
        rd_req_flowid  = '0;
        probe_val      = 1'b0;
        probe_idx      = 0;
        n_reads        = 0;
        run_fail       = 1'b0;
        reset          = 1'b1;
        $readmemh("tests/rx_payload_q_vectors.hex", vecs);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        vi = 0;
        while (vi < VEC_MAX && vecs[vi][75:72] !== 4'hF && !run_fail) begin
            case (vecs[vi][75:72])
                4'h0: enqueue_entry(vi);
                4'h1: begin
                    n_reads++;
                    request_read(vi);
                end
                4'h2: probe_enq_rdy(vi);
                default: begin
                    $display("vector line %0d has an unknown op %h", vi, vecs[vi][75:72]);
                    run_fail = 1'b1;
                end
            endcase
            vi++;
        end

        waited = 0;
        while (!run_fail && resp_cnt < n_reads && waited < WAIT_MAX) begin
            waited++;
            @(posedge clk);
        end
        if (!run_fail && resp_cnt < n_reads) begin
            $display("timeout: only %0d of %0d read responses arrived", resp_cnt, n_reads);
            run_fail = 1'b1;
        end
        // Quiet cycles so a duplicate response would still show up
        repeat (8) @(posedge clk);

        $display("tests %0d, responses %0d, errors %0d, assertion failures %0d",
                 tests_done, resp_cnt, err_cnt, uut.u_chk.fails);
        if (!run_fail && err_cnt == 0 && uut.u_chk.fails == 0 && resp_cnt == n_reads) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/rx_payload_q_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_payload_q_monitor #(
     parameter int VEC_W   = 84
    ,parameter int VEC_MAX = 64
) (
     input  logic                           clk
    ,input  logic                           reset

    ,input  logic [VEC_W-1:0]               vecs [VEC_MAX]
    ,input  logic                           probe_val
    ,input  int                             probe_idx

    ,input  logic                           enq_req_rdy
    ,input  logic                           rd_req_rdy
    ,input  logic                           rd_resp_val
    ,input  logic                           rd_resp_is_empty
    ,input  rx_q_types_pkg::payload_entry_t rd_resp_entry
    ,input  logic                           rd_resp_rdy

    ,output int                             err_cnt
    ,output int                             resp_cnt
    ,output int                             tests_done
);
    int     rd_ptr;
    int     done_cnt [256];
    logic   test_bad [256];
    logic   after_reset_seen;

    // Index of the next read line after from or -1 when none is left
    function automatic int next_read(input int from);
        int i;
        next_read = -1;
        i = from + 1;
        while (i < VEC_MAX && next_read < 0 && vecs[i][75:72] !== 4'hF) begin
            if (vecs[i][75:72] == 4'h1) begin
                next_read = i;
            end
            i++;
        end
    endfunction

    function automatic int checks_in_test(input int t);
        int i;
        checks_in_test = 0;
        i = 0;
        while (i < VEC_MAX && vecs[i][75:72] !== 4'hF) begin
            if (vecs[i][83:76] == t && (vecs[i][75:72] == 4'h1 || vecs[i][75:72] == 4'h2)) begin
                checks_in_test++;
            end
            i++;
        end
    endfunction

    task automatic note_check(input int idx, input logic ok);
        int t;
        t = vecs[idx][83:76];
        done_cnt[t]++;
        if (!ok) begin
            test_bad[t] = 1'b1;
        end
        if (done_cnt[t] == checks_in_test(t)) begin
            $display("test %0d: %s", t, test_bad[t] ? "fail" : "ok");
            tests_done++;
        end
    endtask

    // Outputs are sampled on the falling edge where the inputs have settled
    always @(negedge clk) begin : watch
        int     i;
        int     exp_idx;
        logic   ok;
        if (reset) begin
            err_cnt          = 0;
            resp_cnt         = 0;
            tests_done       = 0;
            rd_ptr           = -1;
            after_reset_seen = 1'b0;
            for (i = 0; i < 256; i++) begin
                done_cnt[i] = 0;
                test_bad[i] = 1'b0;
            end
        end
        else begin
            if (!after_reset_seen) begin
                after_reset_seen = 1'b1;
                if (rd_req_rdy !== 1'b1) begin
                    $display("ERR rd_req_rdy after reset: got %h, expected 1", rd_req_rdy);
                    err_cnt++;
                end
                if (rd_resp_val !== 1'b0) begin
                    $display("ERR rd_resp_val after reset: got %h, expected 0", rd_resp_val);
                    err_cnt++;
                end
            end
            if (probe_val) begin
                ok = (enq_req_rdy === vecs[probe_idx][32]);
                if (!ok) begin
                    $display("ERR enq_req_rdy line %0d: got %h, expected %h",
                             probe_idx, enq_req_rdy, vecs[probe_idx][32]);
                    err_cnt++;
                end
                note_check(probe_idx, ok);
            end
            if (rd_resp_val === 1'b1 && rd_resp_rdy === 1'b1) begin
                resp_cnt++;
                exp_idx = next_read(rd_ptr);
                if (exp_idx < 0) begin
                    $display("read response arrived with no read request left to match it");
                    err_cnt++;
                end
                else begin
                    rd_ptr = exp_idx;
                    ok = 1'b1;
                    if (rd_resp_is_empty !== vecs[exp_idx][32]) begin
                        $display("ERR rd_resp_is_empty line %0d: got %h, expected %h",
                                 exp_idx, rd_resp_is_empty, vecs[exp_idx][32]);
                        ok = 1'b0;
                    end
                    if (rd_resp_entry !== vecs[exp_idx][31:0]) begin
                        $display("ERR rd_resp_entry line %0d: got %h, expected %h",
                                 exp_idx, rd_resp_entry, vecs[exp_idx][31:0]);
                        ok = 1'b0;
                    end
                    if (!ok) begin
                        err_cnt++;
                    end
                    note_check(exp_idx, ok);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/rx_payload_q_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_payload_q_chk (
     input  logic                           clk
    ,input  logic                           reset

    ,input  logic                           rd_req_val
    ,input  logic                           rd_req_rdy

    ,input  logic                           rd_resp_val
    ,input  logic                           rd_resp_is_empty
    ,input  rx_q_types_pkg::payload_entry_t rd_resp_entry
    ,input  logic                           rd_resp_rdy
);
    int fails = 0;

    // A held response keeps its fields until it is taken
    resp_held_stable: assert property (
        @(posedge clk) disable iff (reset)
        rd_resp_val && !rd_resp_rdy |=>
            rd_resp_val && $stable(rd_resp_is_empty) && $stable(rd_resp_entry)
    ) else begin
        $error("read response changed or dropped while held");
        fails++;
    end

    resp_after_req: assert property (
        @(posedge clk) disable iff (reset)
        rd_req_val && rd_req_rdy |=> rd_resp_val
    ) else begin
        $error("no read response one cycle after an accepted request");
        fails++;
    end

    // A rising valid needs an accepted request the cycle before
    resp_rise_has_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(rd_resp_val) |-> $past(rd_req_val && rd_req_rdy)
    ) else begin
        $error("read response rose without an accepted request");
        fails++;
    end

    resp_low_in_reset: assert property (
        @(posedge clk)
        reset |=> !rd_resp_val
    ) else begin
        $error("read response valid during reset");
        fails++;
    end

endmodule

bind rx_payload_q rx_payload_q_chk u_chk (.*);

`default_nettype wire

// ==== hdl/rx_payload_q.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_payload_q (
     input  logic                           clk
    ,input  logic                           reset

    // Enqueue by flow id
    ,input  logic                           enq_req_val
    ,input  rx_q_types_pkg::flow_id_t       enq_req_flowid
    ,input  rx_q_types_pkg::payload_entry_t enq_req_data
    ,output logic                           enq_req_rdy

    // Read the oldest entry of a flow
    ,input  logic                           rd_req_val
    ,input  rx_q_types_pkg::flow_id_t       rd_req_flowid
    ,output logic                           rd_req_rdy

    ,output logic                           rd_resp_val
    ,output logic                           rd_resp_is_empty
    ,output rx_q_types_pkg::payload_entry_t rd_resp_entry
    ,input  logic                           rd_resp_rdy
);
    import rx_q_cfg_pkg::*;

    flow_ring_if ring_if [FLOW_CNT] ();

    enqueue_steer u_enqueue_steer (
         .enq_req_val       (enq_req_val        )
        ,.enq_req_flowid    (enq_req_flowid     )
        ,.enq_req_data      (enq_req_data       )
        ,.enq_req_rdy       (enq_req_rdy        )

        ,.rings             (ring_if            )
    );

    for (genvar i = 0; i < FLOW_CNT; i++) begin : g_flow
        flow_ring u_flow_ring (
             .clk           (clk                )
            ,.reset         (reset              )

            ,.ring          (ring_if[i]         )
        );
    end

    read_resp_stage u_read_resp_stage (
         .clk               (clk                )
        ,.reset             (reset              )

        ,.rd_req_val        (rd_req_val         )
        ,.rd_req_flowid     (rd_req_flowid      )
        ,.rd_req_rdy        (rd_req_rdy         )

        ,.rd_resp_val       (rd_resp_val        )
        ,.rd_resp_is_empty  (rd_resp_is_empty   )
        ,.rd_resp_entry     (rd_resp_entry      )
        ,.rd_resp_rdy       (rd_resp_rdy        )

        ,.rings             (ring_if            )
    );

endmodule

`default_nettype wire

// ==== hdl/read_resp_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_resp_stage (
     input  logic                           clk
    ,input  logic                           reset

    ,input  logic                           rd_req_val
    ,input  rx_q_types_pkg::flow_id_t       rd_req_flowid
    ,output logic                           rd_req_rdy

    ,output logic                           rd_resp_val
    ,output logic                           rd_resp_is_empty
    ,output rx_q_types_pkg::payload_entry_t rd_resp_entry
    ,input  logic                           rd_resp_rdy

    ,flow_ring_if.consumer                  rings [rx_q_cfg_pkg::FLOW_CNT]
);
    import rx_q_cfg_pkg::*;
    import rx_q_types_pkg::*;

    logic [FLOW_CNT-1:0]    empty_vec;
    payload_entry_t         head_data_arr [FLOW_CNT];

    logic                   req_xfer;
    logic                   sel_empty;
    payload_entry_t         sel_data;

    logic                   resp_val_reg;
    logic                   resp_is_empty_reg;
    payload_entry_t         resp_entry_reg;

    for (genvar i = 0; i < FLOW_CNT; i++) begin : g_ring
        assign empty_vec[i]     = rings[i].empty;
        assign head_data_arr[i] = rings[i].head_data;

        // An empty ring is answered without being popped
        assign rings[i].pop = req_xfer && (rd_req_flowid == flow_id_t'(i))
                              && !rings[i].empty;
    end

    // One response slot that can refill in the cycle it drains
    assign rd_req_rdy = ~resp_val_reg | rd_resp_rdy;
    assign req_xfer   = rd_req_val & rd_req_rdy;

    assign sel_empty = empty_vec[rd_req_flowid];
    assign sel_data  = head_data_arr[rd_req_flowid];

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_val_reg <= 1'b0;
        end
        else if (req_xfer) begin
            resp_val_reg <= 1'b1;
        end
        else if (rd_resp_rdy) begin
            resp_val_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_xfer) begin
            resp_is_empty_reg <= sel_empty;
            // Zero entry on an empty answer
            resp_entry_reg    <= sel_empty ? '0 : sel_data;
        end
    end

    assign rd_resp_val      = resp_val_reg;
    assign rd_resp_is_empty = resp_is_empty_reg;
    assign rd_resp_entry    = resp_entry_reg;

endmodule

`default_nettype wire

// ==== hdl/enqueue_steer.sv ====
`timescale 1ns/100ps
`default_nettype none

module enqueue_steer (
     input  logic                           enq_req_val
    ,input  rx_q_types_pkg::flow_id_t       enq_req_flowid
    ,input  rx_q_types_pkg::payload_entry_t enq_req_data
    ,output logic                           enq_req_rdy

    ,flow_ring_if.producer                  rings [rx_q_cfg_pkg::FLOW_CNT]
);
    import rx_q_cfg_pkg::*;
    import rx_q_types_pkg::*;

    logic [FLOW_CNT-1:0]    full_vec;
    logic                   enq_xfer;

    for (genvar i = 0; i < FLOW_CNT; i++) begin : g_ring
        assign full_vec[i] = rings[i].full;

        // Data goes everywhere but only the addressed ring sees push
        assign rings[i].push_data = enq_req_data;
        assign rings[i].push      = enq_xfer && (enq_req_flowid == flow_id_t'(i));
    end

    assign enq_req_rdy = ~full_vec[enq_req_flowid];
    assign enq_xfer    = enq_req_val & enq_req_rdy;

endmodule

`default_nettype wire

// ==== hdl/flow_ring.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_ring (
     input  logic       clk
    ,input  logic       reset

    ,flow_ring_if.ring  ring
);
    import rx_q_cfg_pkg::*;
    import rx_q_types_pkg::*;

    payload_entry_t         entries [RING_DEPTH];

    ring_ptr_t              head_ptr;
    ring_ptr_t              tail_ptr;

    logic [RING_IDX_W-1:0]  head_idx;
    logic [RING_IDX_W-1:0]  tail_idx;
    logic                   head_wrap;
    logic                   tail_wrap;

    assign head_idx  = head_ptr[RING_IDX_W-1:0];
    assign tail_idx  = tail_ptr[RING_IDX_W-1:0];
    assign head_wrap = head_ptr[RING_IDX_W];
    assign tail_wrap = tail_ptr[RING_IDX_W];

    // Same slot on different laps means the ring has caught up with itself
    assign ring.full  = (head_idx == tail_idx) && (head_wrap != tail_wrap);
    assign ring.empty = (head_ptr == tail_ptr);

    // Oldest entry is always presented
    assign ring.head_data = entries[head_idx];

    // Callers guarantee no push when full and no pop when empty
    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end
        else begin
            if (ring.push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (ring.pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ring.push) begin
            entries[tail_idx] <= ring.push_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/flow_ring_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface flow_ring_if;
    import rx_q_types_pkg::*;

    // Enqueue side
    logic           push;
    payload_entry_t push_data;
    logic           full;

    // Dequeue side
    logic           pop;
    payload_entry_t head_data;
    logic           empty;

    modport producer (
        output push,
        output push_data,
        input  full
    );

    modport consumer (
        output pop,
        input  head_data,
        input  empty
    );

    modport ring (
        input  push,
        input  push_data,
        input  pop,
        output full,
        output head_data,
        output empty
    );

endinterface

`default_nettype wire

// ==== hdl/rx_q_types_pkg.sv ====
`default_nettype none

package rx_q_types_pkg;
    import rx_q_cfg_pkg::*;

    typedef logic [FLOW_ID_W-1:0] flow_id_t;

    typedef logic [ENTRY_W-1:0] payload_entry_t;

    // Top bit is the wrap bit and the rest indexes the ring
    typedef logic [RING_IDX_W:0] ring_ptr_t;

endpackage

`default_nettype wire

// ==== hdl/rx_q_cfg_pkg.sv ====
`default_nettype none

package rx_q_cfg_pkg;

    // Number of independent receive flows
    localparam int FLOW_CNT = 4;

    // Flow id width as log2 of FLOW_CNT
    localparam int FLOW_ID_W = 2;

    // Entries per flow ring as a power of two
    localparam int RING_DEPTH = 8;

    // Entry index width as log2 of RING_DEPTH
    localparam int RING_IDX_W = 3;

    // One payload word
    localparam int ENTRY_W = 32;

endpackage

`default_nettype wire
